// ==== Makefile ====
SRCS := $(wildcard design/*.sv test/*.sv)

.PHONY: run clean

run: obj_dir/Vproc_tb
	./obj_dir/Vproc_tb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

obj_dir/Vproc_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module proc_tb -f vlog.f

clean:
	rm -rf obj_dir sim.log

// ==== design/imul_iter.sv ====
`timescale 1ns/100ps

module imul_iter #(
  parameter int mul_width = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_val,
  output logic                 req_rdy,
  input  logic [mul_width-1:0] op_a,
  input  logic [mul_width-1:0] op_b,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output logic [mul_width-1:0] result
);

  localparam int cnt_w = (mul_width > 1) ? $clog2(mul_width) : 1;

  typedef enum logic [1:0] {IDLE, BUSY, DONE} state_e;

  state_e               state;
  logic [cnt_w-1:0]     count;
  logic [mul_width-1:0] mcand;
  logic [mul_width-1:0] mplier;
  logic [mul_width-1:0] acc;

  // One step per busy cycle and mul_width steps in all
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: if (req_val) begin
          state <= BUSY;
          count <= cnt_w'(mul_width - 1);
        end
        BUSY: begin
          count <= count - 1'b1;
          if (count == '0) state <= DONE;
        end
        DONE: if (resp_rdy) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Shift-add keeping only the low word of the product
  always_ff @(posedge clk) begin
    if (state == IDLE && req_val) begin
      mcand  <= op_a;
      mplier <= op_b;
      acc    <= '0;
    end else if (state == BUSY) begin
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign result   = acc;

endmodule

// ==== design/proc_ctrl.sv ====
`timescale 1ns/100ps

module proc_ctrl (
  input  logic       clk,
  input  logic       rst_n,

  // Instruction fetch streams
  output logic       imem_req_val,
  input  logic       imem_req_rdy,
  input  logic       imem_resp_val,
  output logic       imem_resp_rdy,

  // Manager streams
  input  logic       mngr2proc_val,
  output logic       mngr2proc_rdy,
  output logic       proc2mngr_val,
  input  logic       proc2mngr_rdy,

  proc_ctrl_if.ctrl  ctrl_if
);
  import proc_pkg::*;

  typedef enum logic [2:0] {
    FETCH_REQ,
    FETCH_RESP,
    EXEC,
    MUL_REQ,
    MUL_WAIT,
    MNGR_IN,
    MNGR_OUT
  } state_e;

  state_e state;
  state_e state_next;
  logic   started;

  // Started holds off the first fetch for one cycle out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= FETCH_REQ;
      started <= 1'b0;
    end else begin
      state   <= state_next;
      started <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Next state and control outputs
  // ----------------------------------------------------------

  always_comb begin
    state_next           = state;
    imem_req_val         = 1'b0;
    imem_resp_rdy        = 1'b0;
    mngr2proc_rdy        = 1'b0;
    proc2mngr_val        = 1'b0;
    ctrl_if.pc_en        = 1'b0;
    ctrl_if.pc_sel_br    = 1'b0;
    ctrl_if.ir_en        = 1'b0;
    ctrl_if.rf_wen       = 1'b0;
    ctrl_if.wb_sel       = WB_ALU;
    ctrl_if.mul_req_val  = 1'b0;
    ctrl_if.mul_resp_rdy = 1'b0;

    case (state)
      FETCH_REQ: begin
        imem_req_val = started;
        if (started && imem_req_rdy) state_next = FETCH_RESP;
      end
      FETCH_RESP: begin
        imem_resp_rdy = 1'b1;
        if (imem_resp_val) begin
          ctrl_if.ir_en = 1'b1;
          state_next    = EXEC;
        end
      end
      EXEC: begin
        case (ctrl_if.opcode)
          OP_ADDI, OP_ADD: begin
            ctrl_if.rf_wen = 1'b1;
            ctrl_if.pc_en  = 1'b1;
            state_next     = FETCH_REQ;
          end
          OP_BNE: begin
            ctrl_if.pc_en     = 1'b1;
            ctrl_if.pc_sel_br = ctrl_if.br_ne;
            state_next        = FETCH_REQ;
          end
          OP_MUL:  state_next = MUL_REQ;
          OP_CSRR: state_next = MNGR_IN;
          OP_CSRW: state_next = MNGR_OUT;
          // Unknown codes just advance the PC
          default: begin
            ctrl_if.pc_en = 1'b1;
            state_next    = FETCH_REQ;
          end
        endcase
      end
      MUL_REQ: begin
        ctrl_if.mul_req_val = 1'b1;
        if (ctrl_if.mul_req_rdy) state_next = MUL_WAIT;
      end
      MUL_WAIT: begin
        ctrl_if.mul_resp_rdy = 1'b1;
        ctrl_if.wb_sel       = WB_MUL;
        if (ctrl_if.mul_resp_val) begin
          ctrl_if.rf_wen = 1'b1;
          ctrl_if.pc_en  = 1'b1;
          state_next     = FETCH_REQ;
        end
      end
      MNGR_IN: begin
        mngr2proc_rdy  = 1'b1;
        ctrl_if.wb_sel = WB_MNGR;
        if (mngr2proc_val) begin
          ctrl_if.rf_wen = 1'b1;
          ctrl_if.pc_en  = 1'b1;
          state_next     = FETCH_REQ;
        end
      end
      MNGR_OUT: begin
        proc2mngr_val = 1'b1;
        if (proc2mngr_rdy) begin
          ctrl_if.pc_en = 1'b1;
          state_next    = FETCH_REQ;
        end
      end
      default: state_next = FETCH_REQ;
    endcase
  end

endmodule

// ==== design/proc_ctrl_if.sv ====
`timescale 1ns/100ps

interface proc_ctrl_if;
  import proc_pkg::*;

  // Control from ctrl to dpath
  logic    pc_en;
  logic    pc_sel_br;
  logic    ir_en;
  logic    rf_wen;
  wb_sel_e wb_sel;
  logic    mul_req_val;
  logic    mul_resp_rdy;

  // Status from dpath to ctrl
  opcode_e opcode;
  logic    br_ne;
  logic    mul_req_rdy;
  logic    mul_resp_val;

  modport ctrl (
    output pc_en, pc_sel_br, ir_en, rf_wen, wb_sel, mul_req_val, mul_resp_rdy,
    input  opcode, br_ne, mul_req_rdy, mul_resp_val
  );

  modport dpath (
    input  pc_en, pc_sel_br, ir_en, rf_wen, wb_sel, mul_req_val, mul_resp_rdy,
    output opcode, br_ne, mul_req_rdy, mul_resp_val
  );

endinterface

// ==== design/proc_dpath.sv ====
`timescale 1ns/100ps

module proc_dpath #(
  parameter proc_pkg::addr_t reset_pc  = '0,
  parameter int              mul_width = 32
) (
  input  logic            clk,
  input  logic            rst_n,
  output proc_pkg::addr_t imem_req_addr,
  input  proc_pkg::inst_t imem_resp_data,
  input  proc_pkg::word_t mngr2proc_msg,
  output proc_pkg::word_t proc2mngr_msg,
  proc_ctrl_if.dpath      ctrl_if
);
  import proc_pkg::*;

  addr_t    pc;
  addr_t    pc_plus4;
  addr_t    br_target;
  inst_t    ir;
  word_t    rf [0:7];
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    imm_sext;
  word_t    alu_op2;
  word_t    alu_out;
  word_t    mul_word;
  word_t    wb_data;

  logic [mul_width-1:0] mul_a;
  logic [mul_width-1:0] mul_b;
  logic [mul_width-1:0] mul_result;

  // ----------------------------------------------------------
  // PC and instruction register
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pc <= reset_pc;
    else if (ctrl_if.pc_en) pc <= ctrl_if.pc_sel_br ? br_target : pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (ctrl_if.ir_en) ir <= imem_resp_data;
  end

  assign imem_req_addr = pc;
  assign pc_plus4      = pc + 32'd4;

  // Branch offset counts words
  assign br_target = pc + {imm_sext[29:0], 2'b00};

  // Decode
  assign ctrl_if.opcode = opcode_e'(ir[opc_msb:opc_lsb]);
  assign rd       = ir[rd_msb:rd_lsb];
  assign rs1      = ir[rs1_msb:rs1_lsb];
  assign rs2      = ir[rs2_msb:rs2_lsb];
  assign imm_sext = {{(31 - imm_msb){ir[imm_msb]}}, ir[imm_msb:imm_lsb]};

  // ----------------------------------------------------------
  // Register file with r0 reading as zero
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl_if.rf_wen && rd != '0) rf[rd] <= wb_data;
  end

  assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

  // ALU and branch compare
  assign alu_op2       = (ctrl_if.opcode == OP_ADDI) ? imm_sext : rs2_val;
  assign alu_out       = rs1_val + alu_op2;
  assign ctrl_if.br_ne = (rs1_val != rs2_val);
  assign proc2mngr_msg = rs1_val;

  // Multiplier on the low mul_width bits of the operands
  assign mul_a    = rs1_val[mul_width-1:0];
  assign mul_b    = rs2_val[mul_width-1:0];
  assign mul_word = word_t'(mul_result);

  imul_iter #(
    .mul_width (mul_width)
  ) u_imul_iter (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_val  (ctrl_if.mul_req_val),
    .req_rdy  (ctrl_if.mul_req_rdy),
    .op_a     (mul_a),
    .op_b     (mul_b),
    .resp_val (ctrl_if.mul_resp_val),
    .resp_rdy (ctrl_if.mul_resp_rdy),
    .result   (mul_result)
  );

  // Writeback select
  always_comb begin
    case (ctrl_if.wb_sel)
      WB_MUL:  wb_data = mul_word;
      WB_MNGR: wb_data = mngr2proc_msg;
      default: wb_data = alu_out;
    endcase
  end

endmodule

// ==== design/proc_pkg.sv ====
package proc_pkg;

  // ----------------------------------------------------------
  // Data, address and instruction types
  // ----------------------------------------------------------

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [2:0]  reg_idx_t;

  // ----------------------------------------------------------
  // Instruction field positions
  // ----------------------------------------------------------

  localparam int opc_msb = 31;
  localparam int opc_lsb = 28;
  localparam int rd_msb  = 26;
  localparam int rd_lsb  = 24;
  localparam int rs1_msb = 22;
  localparam int rs1_lsb = 20;
  localparam int rs2_msb = 18;
  localparam int rs2_lsb = 16;
  localparam int imm_msb = 15;
  localparam int imm_lsb = 0;

  // Any opcode not listed here executes as a no-op
  typedef enum logic [3:0] {
    OP_ADDI = 4'h1,
    OP_ADD  = 4'h2,
    OP_MUL  = 4'h3,
    OP_BNE  = 4'h4,
    OP_CSRR = 4'h5,
    OP_CSRW = 4'h6
  } opcode_e;

  // Register writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MUL,
    WB_MNGR
  } wb_sel_e;

endpackage

// ==== design/proc_top.sv ====
`timescale 1ns/100ps

module proc_top #(
  parameter proc_pkg::addr_t reset_pc  = '0,
  parameter int              mul_width = 32
) (
  input  logic            clk,
  input  logic            rst_n,

  // Instruction fetch request
  output proc_pkg::addr_t imem_req_addr,
  output logic            imem_req_val,
  input  logic            imem_req_rdy,

  // Instruction fetch response
  input  proc_pkg::inst_t imem_resp_data,
  input  logic            imem_resp_val,
  output logic            imem_resp_rdy,

  // From manager
  input  proc_pkg::word_t mngr2proc_msg,
  input  logic            mngr2proc_val,
  output logic            mngr2proc_rdy,

  // To manager
  output proc_pkg::word_t proc2mngr_msg,
  output logic            proc2mngr_val,
  input  logic            proc2mngr_rdy
);

  // ----------------------------------------------------------
  // Control and datapath
  // ----------------------------------------------------------

  proc_ctrl_if u_ctrl_if ();

  proc_ctrl u_proc_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .imem_req_val  (imem_req_val),
    .imem_req_rdy  (imem_req_rdy),
    .imem_resp_val (imem_resp_val),
    .imem_resp_rdy (imem_resp_rdy),
    .mngr2proc_val (mngr2proc_val),
    .mngr2proc_rdy (mngr2proc_rdy),
    .proc2mngr_val (proc2mngr_val),
    .proc2mngr_rdy (proc2mngr_rdy),
    .ctrl_if       (u_ctrl_if.ctrl)
  );

  proc_dpath #(
    .reset_pc  (reset_pc),
    .mul_width (mul_width)
  ) u_proc_dpath (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_data (imem_resp_data),
    .mngr2proc_msg  (mngr2proc_msg),
    .proc2mngr_msg  (proc2mngr_msg),
    .ctrl_if        (u_ctrl_if.dpath)
  );

endmodule

// ==== test/proc_assert.sv ====
`timescale 1ns/100ps

module proc_assert (
  input logic            clk,
  input logic            rst_n,
  input proc_pkg::addr_t imem_req_addr,
  input logic            imem_req_val,
  input logic            imem_req_rdy,
  input logic            imem_resp_rdy,
  input logic            mngr2proc_rdy,
  input proc_pkg::word_t proc2mngr_msg,
  input logic            proc2mngr_val,
  input logic            proc2mngr_rdy
);

  int fail_count = 0;

  // ----------------------------------------------------------
  // Reset and stream rules
  // ----------------------------------------------------------

  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !imem_req_val && !imem_resp_rdy && !mngr2proc_rdy && !proc2mngr_val)
    else begin
      fail_count++;
      $error("A stream handshake output was high during reset");
    end

  out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    proc2mngr_val && !proc2mngr_rdy |=> proc2mngr_val && $stable(proc2mngr_msg))
    else begin
      fail_count++;
      $error("Outbound manager message changed before it was taken");
    end

  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_val && !imem_req_rdy |=> imem_req_val && $stable(imem_req_addr))
    else begin
      fail_count++;
      $error("Fetch request changed before it was accepted");
    end

  // Output values
  out_known: assert property (@(posedge clk) disable iff (!rst_n)
    proc2mngr_val |-> !$isunknown(proc2mngr_msg))
    else begin
      fail_count++;
      $error("Outbound manager message holds unknown bits");
    end

endmodule

bind proc_top proc_assert u_proc_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .imem_req_addr (imem_req_addr),
  .imem_req_val  (imem_req_val),
  .imem_req_rdy  (imem_req_rdy),
  .imem_resp_rdy (imem_resp_rdy),
  .mngr2proc_rdy (mngr2proc_rdy),
  .proc2mngr_msg (proc2mngr_msg),
  .proc2mngr_val (proc2mngr_val),
  .proc2mngr_rdy (proc2mngr_rdy)
);

// ==== test/proc_tb.sv ====
`timescale 1ns/100ps

module proc_tb;
  import proc_pkg::*;

  localparam int          half_period  = 50;
  localparam int          reset_cycles = 16;
  localparam int          wait_limit   = 2000;
  localparam int          quiet_cycles = 300;
  localparam logic [31:0] seed         = 32'h0103_7da5;

  logic  clk;
  logic  rst_n;
  addr_t imem_req_addr;
  logic  imem_req_val;
  logic  imem_req_rdy;
  inst_t imem_resp_data;
  logic  imem_resp_val;
  logic  imem_resp_rdy;
  word_t mngr2proc_msg;
  logic  mngr2proc_val;
  logic  mngr2proc_rdy;
  word_t proc2mngr_msg;
  logic  proc2mngr_val;
  logic  proc2mngr_rdy;

  inst_t       imem [0:63];
  logic [31:0] imem_rng;
  logic [31:0] mngr_rng;
  logic [31:0] sink_rng;
  int          errors;
  logic        fetch_stalled;
  word_t       a_val;
  word_t       b_val;
  word_t       got;
  logic        ok;

  proc_top u_proc_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_req_addr  (imem_req_addr),
    .imem_req_val   (imem_req_val),
    .imem_req_rdy   (imem_req_rdy),
    .imem_resp_data (imem_resp_data),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_rdy  (imem_resp_rdy),
    .mngr2proc_msg  (mngr2proc_msg),
    .mngr2proc_val  (mngr2proc_val),
    .mngr2proc_rdy  (mngr2proc_rdy),
    .proc2mngr_msg  (proc2mngr_msg),
    .proc2mngr_val  (proc2mngr_val),
    .proc2mngr_rdy  (proc2mngr_rdy)
  );

  always #half_period clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic inst_t encode(input opcode_e op, input reg_idx_t rd,
                                   input reg_idx_t rs1, input reg_idx_t rs2,
                                   input logic [15:0] imm);
    inst_t inst;
    inst = '0;
    inst[opc_msb:opc_lsb] = op;
    inst[rd_msb:rd_lsb]   = rd;
    inst[rs1_msb:rs1_lsb] = rs1;
    inst[rs2_msb:rs2_lsb] = rs2;
    inst[imm_msb:imm_lsb] = imm;
    return inst;
  endfunction

  // ----------------------------------------------------------
  // Program image
  // ----------------------------------------------------------

  task automatic load_program;
    int i;
    // Unused words hold a CSRW tagged with its byte address so a stray fetch makes output
    for (i = 0; i < 64; i++) begin
      imem[i] = {OP_CSRW, 28'(i * 4)};
    end
    imem[0]  = encode(OP_CSRR, 3'd1, 3'd0, 3'd0, 16'h0000);
    imem[1]  = encode(OP_CSRR, 3'd2, 3'd0, 3'd0, 16'h0000);
    imem[2]  = encode(OP_ADD,  3'd3, 3'd1, 3'd2, 16'h0000);
    imem[3]  = encode(OP_CSRW, 3'd0, 3'd3, 3'd0, 16'h0000);
    imem[4]  = encode(OP_MUL,  3'd4, 3'd1, 3'd2, 16'h0000);
    imem[5]  = encode(OP_CSRW, 3'd0, 3'd4, 3'd0, 16'h0000);
    imem[6]  = encode(OP_ADDI, 3'd5, 3'd0, 3'd0, 16'h0000);
    imem[7]  = encode(OP_ADDI, 3'd6, 3'd0, 3'd0, 16'h0005);
    // Loop body runs five passes adding 3
    imem[8]  = encode(OP_ADDI, 3'd5, 3'd5, 3'd0, 16'h0003);
    imem[9]  = encode(OP_ADDI, 3'd6, 3'd6, 3'd0, 16'hffff);
    imem[10] = encode(OP_BNE,  3'd0, 3'd6, 3'd0, 16'hfffe);
    imem[11] = encode(OP_CSRW, 3'd0, 3'd5, 3'd0, 16'h0000);
    imem[12] = encode(OP_ADDI, 3'd7, 3'd0, 3'd0, 16'h0001);
    imem[13] = encode(OP_BNE,  3'd0, 3'd7, 3'd0, 16'h0000);
  endtask

  // Instruction memory serving one fetch per call
  task automatic serve_fetch;
    int    n;
    int    delay;
    addr_t addr;
    logic  taken;
    taken = 1'b0;
    addr  = '0;
    n     = 0;
    while (!taken && n < wait_limit) begin
      imem_rng     = xorshift32(imem_rng);
      imem_req_rdy = imem_rng[0];
      @(negedge clk);
      if (imem_req_val && imem_req_rdy) begin
        taken = 1'b1;
        addr  = imem_req_addr;
      end
      @(posedge clk);
      #1;
      n++;
    end
    imem_req_rdy = 1'b0;
    if (!taken) begin
      errors++;
      $display("Timeout: no instruction fetch request was accepted");
      fetch_stalled = 1'b1;
      return;
    end
    imem_rng = xorshift32(imem_rng);
    delay    = int'(imem_rng[2:1]);
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
    imem_resp_data = imem[addr[7:2]];
    imem_resp_val  = 1'b1;
    taken          = 1'b0;
    n              = 0;
    while (!taken && n < wait_limit) begin
      @(negedge clk);
      taken = imem_resp_rdy;
      @(posedge clk);
      #1;
      n++;
    end
    imem_resp_val = 1'b0;
    if (!taken) begin
      errors++;
      $display("Timeout: the processor never took the instruction response");
      fetch_stalled = 1'b1;
    end
  endtask

  task automatic send_value(input word_t value);
    int   n;
    logic done;
    mngr2proc_msg = value;
    mngr2proc_val = 1'b1;
    done          = 1'b0;
    n             = 0;
    while (!done && n < wait_limit) begin
      @(negedge clk);
      done = mngr2proc_rdy;
      @(posedge clk);
      #1;
      n++;
    end
    mngr2proc_val = 1'b0;
    if (!done) begin
      errors++;
      $display("Timeout: the processor did not read the manager input");
    end
  endtask

  // Manager sink with pseudo-random back-pressure
  task automatic receive_output(input int idx, output word_t msg, output logic got_it);
    int n;
    got_it = 1'b0;
    msg    = '0;
    n      = 0;
    while (!got_it && n < wait_limit) begin
      sink_rng      = xorshift32(sink_rng);
      proc2mngr_rdy = sink_rng[0];
      @(negedge clk);
      if (proc2mngr_val && proc2mngr_rdy) begin
        got_it = 1'b1;
        msg    = proc2mngr_msg;
      end
      @(posedge clk);
      #1;
      n++;
    end
    proc2mngr_rdy = 1'b0;
    if (!got_it) begin
      errors++;
      $display("Timeout: output %0d never arrived from the processor", idx);
    end
  endtask

  task automatic compare_output(input int idx, input word_t actual, input word_t expected);
    assert (actual == expected) else begin
      errors++;
      $display("Mismatch proc2mngr_msg output %0d: expected %h, got %h",
               idx, expected, actual);
    end
  endtask

  // The self-branch must keep the output stream silent
  task automatic expect_no_output;
    int   n;
    logic seen;
    seen          = 1'b0;
    proc2mngr_rdy = 1'b1;
    for (n = 0; n < quiet_cycles && !seen; n++) begin
      @(negedge clk);
      seen = proc2mngr_val;
      @(posedge clk);
      #1;
    end
    proc2mngr_rdy = 1'b0;
    assert (!seen) else begin
      errors++;
      $display("An extra output appeared after the last expected value");
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    imem_req_rdy   = 1'b0;
    imem_resp_data = '0;
    imem_resp_val  = 1'b0;
    mngr2proc_msg  = '0;
    mngr2proc_val  = 1'b0;
    proc2mngr_rdy  = 1'b0;
    errors         = 0;
    fetch_stalled  = 1'b0;
    imem_rng       = seed ^ 32'h5a5a_5a5a;
    sink_rng       = seed ^ 32'hc3c3_3c3c;
    mngr_rng       = xorshift32(seed);
    a_val          = mngr_rng;
    mngr_rng       = xorshift32(mngr_rng);
    b_val          = mngr_rng;
    load_program();

    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fork
      while (!fetch_stalled) serve_fetch();
    join_none

    send_value(a_val);
    send_value(b_val);

    receive_output(1, got, ok);
    if (ok) compare_output(1, got, a_val + b_val);
    receive_output(2, got, ok);
    if (ok) compare_output(2, got, a_val * b_val);
    receive_output(3, got, ok);
    if (ok) compare_output(3, got, 32'd15);
    expect_no_output();

    $display("Errors: %0d, assertion failures: %0d", errors,
             u_proc_top.u_proc_assert.fail_count);
    if (errors == 0 && u_proc_top.u_proc_assert.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
design/proc_pkg.sv
design/proc_ctrl_if.sv
design/imul_iter.sv
design/proc_ctrl.sv
design/proc_dpath.sv
design/proc_top.sv
test/proc_assert.sv
test/proc_tb.sv
